/* include/uopFields.svh */
// Instruction field positions
`ifndef UOP_FIELDS_SVH
`define UOP_FIELDS_SVH

localparam int condHi = 31;                 // condition code
localparam int condLo = 28;
localparam int classHi = 27;                // instruction class
localparam int classLo = 25;
localparam int opcHi = 24;                  // dp opcode, also mul/long marker bit
localparam int longBit = 23;                // long multiply
localparam int accBit = 21;                 // accumulate
localparam int sBit = 20;                   // flag update
localparam int rnHi = 19;                   // Rn, Rd / RdHi for multiplies
localparam int rnLo = 16;
localparam int rdHi = 15;                   // Rd, Rn / RdLo for multiplies
localparam int rdLo = 12;
localparam int rsHi = 11;                   // top of Rs and of the shifter operand
localparam int shiftLo = 4;                 // bottom of the shift field
localparam int rmHi = 3;
localparam int rmLo = 0;
localparam int regShiftBit = 4;             // set for register-shifted operand
localparam int mulMarkBit = 7;              // clear for rsr, set for multiply
localparam int sigHi = 7;                   // multiply signature
localparam int sigLo = 4;

localparam logic [3:0] mulSig = 4'b1001;
localparam logic [2:0] classDp = 3'b000;    // data processing, register operand
localparam logic [3:0] opcMov = 4'b1101;
localparam logic [3:0] opcAdd = 4'b0100;
localparam logic [3:0] opcAdc = 4'b0101;
localparam logic [3:0] rzNibble = 4'b1111;  // low nibble of rz in the extended bank

`endif

/* rtl/decodePkg.sv */
// Decode stage types
package decodePkg;

	`include "uopFields.svh"

	typedef logic [31:0] instrT;                 // one instruction word
	typedef logic [4:0] regAddrT;                // bit 4 selects extended bank

	localparam regAddrT rzAddr = {1'b1, rzNibble}; // only defined extended register

	typedef enum logic [1:0] {
		ready,                                     // idle, words pass through
		rsr,                                       // second half of rsr
		multiply,                                  // accumulate after mul into rz
		multiply2                                  // high half of long accumulate
	} uopStateT;

	typedef struct packed {
		logic instrMux;                            // word is a generated uop
		logic doNotUpdateFlag;
		logic keepV;                               // multiply family leaves V alone
		logic prevRsr;                             // last uop of a sequence
		logic [3:0] rzSel;                         // {ra1 is rz, ext wa3, ext ra2, ext ra1}
	} uopCtrlT;

	typedef struct packed {
		logic valid;
		instrT uopInstr;
		uopCtrlT ctrl;
		logic [31:0] rd1;
		logic [31:0] rd2;
	} decodeOutT;

	typedef struct packed {
		logic en;
		regAddrT addr;
		logic [31:0] data;
	} writebackT;

	// data processing with the shift amount taken from Rs
	function automatic logic isRsr(instrT w);
		return (w[classHi:classLo] == classDp) && !w[mulMarkBit] && w[regShiftBit];
	endfunction

	// MLA or the long accumulates UMLAL/SMLAL
	function automatic logic isMla(instrT w);
		return (w[classHi:classLo] == classDp) && !w[opcHi] && w[accBit] &&
			(w[sigHi:sigLo] == mulSig);
	endfunction

	function automatic logic isLongAcc(instrT w);
		return isMla(w) && w[longBit];
	endfunction

endpackage

/* rtl/fetchDecodeReg.sv */
// Fetch to decode register
module fetchDecodeReg (
	input logic clk,
	input logic reset,
	input decodePkg::instrT fetchInstr,
	input logic fetchValid,
	input logic hold,                         // uop sequence or downstream stall
	output decodePkg::instrT decodeInstr,
	output logic decodeValid
);

	// valid bit of the word in decode
	always_ff @(posedge clk) begin
		if (reset) begin
			decodeValid <= 1'b0;
		end else if (!hold) begin
			decodeValid <= fetchValid;          // bubble when fetch has nothing
		end
	end

	// payload only moves when decode is free
	always_ff @(posedge clk) begin
		if (!hold) begin
			decodeInstr <= fetchInstr;
		end
	end

	// the sequencer re-reads the same word on every micro-op step,
	// so it must not move for the edge that follows a hold cycle
	holdKeepsWord: assert property (
		@(posedge clk) disable iff (reset)
		hold |=> ($stable(decodeInstr) && $stable(decodeValid))
	) else $error("decode word changed while held");

endmodule

/* rtl/microOpSequencer.sv */
// Micro-op sequencer
module microOpSequencer (
	input logic clk,
	input logic reset,
	input decodePkg::instrT decodeInstr,
	input logic decodeValid,
	input logic exStall,                      // freezes the sequence
	output decodePkg::instrT uopInstr,
	output decodePkg::uopCtrlT ctrl,
	output logic uOpStall                     // keep the word in decode
);

	import decodePkg::*;

	uopStateT state;
	uopStateT nextState;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ready;
		end else if (!exStall) begin
			state <= nextState;                 // held as long as ex is stalled
		end
	end

	// Mealy outputs straight from the word in decode
	always_comb begin
		case (state)
			ready: begin
				if (decodeValid && isRsr(decodeInstr)) begin
					// MOV rz, Rm shift Rs with flags untouched
					uopInstr = {decodeInstr[condHi:classLo], opcMov, 1'b0,
						4'b0000, rzNibble, decodeInstr[rsHi:rmLo]};
					ctrl = '{instrMux: 1'b1, doNotUpdateFlag: 1'b1, keepV: 1'b0,
						prevRsr: 1'b0, rzSel: 4'b1100};  // write rz, ra1 forced to rz
					uOpStall = 1'b1;
					nextState = rsr;
				end else if (decodeValid && isMla(decodeInstr)) begin
					// plain multiply, accumulate and S cleared, result into rz
					// long form points both halves at rz, lo first then hi
					uopInstr = {decodeInstr[condHi:accBit + 1], 1'b0, 1'b0, rzNibble,
						isLongAcc(decodeInstr) ? rzNibble : 4'b0000,
						decodeInstr[rsHi:rmLo]};
					ctrl = '{instrMux: 1'b1, doNotUpdateFlag: 1'b0, keepV: 1'b1,
						prevRsr: 1'b0, rzSel: 4'b0100};  // ext write bit only
					uOpStall = 1'b1;
					nextState = multiply;
				end else begin
					uopInstr = decodeInstr;           // simple word, untouched
					ctrl = '0;
					uOpStall = 1'b0;
					nextState = ready;
				end
			end
			rsr: begin
				// original op with an unshifted rz as operand 2
				uopInstr = {decodeInstr[condHi:rdLo], 8'b0000_0000, rzNibble};
				ctrl = '{instrMux: 1'b1, doNotUpdateFlag: 1'b0, keepV: 1'b0,
					prevRsr: 1'b1, rzSel: 4'b0010};    // ra2 reads rz
				uOpStall = 1'b0;
				nextState = ready;
			end
			multiply: begin
				if (isLongAcc(decodeInstr)) begin
					// ADDS RdLo, rz, RdLo with carry kept inside ex for the hi add
					uopInstr = {decodeInstr[condHi:condLo], classDp, opcAdd, 1'b1,
						rzNibble, decodeInstr[rdHi:rdLo], 8'b0000_0000,
						decodeInstr[rdHi:rdLo]};
					ctrl = '{instrMux: 1'b1, doNotUpdateFlag: 1'b1, keepV: 1'b1,
						prevRsr: 1'b0, rzSel: 4'b0001};  // ra1 reads rz
					uOpStall = 1'b1;                  // one more uop to go
					nextState = multiply2;
				end else begin
					// ADD Rd, rz, Rn, S from the original MLA
					uopInstr = {decodeInstr[condHi:condLo], classDp, opcAdd,
						decodeInstr[sBit], rzNibble, decodeInstr[rnHi:rnLo],
						8'b0000_0000, decodeInstr[rdHi:rdLo]};
					ctrl = '{instrMux: 1'b1, doNotUpdateFlag: 1'b0, keepV: 1'b1,
						prevRsr: 1'b1, rzSel: 4'b0001};
					uOpStall = 1'b0;
					nextState = ready;
				end
			end
			multiply2: begin
				// ADC RdHi, rz, RdHi where rz now holds the product hi half
				uopInstr = {decodeInstr[condHi:condLo], classDp, opcAdc,
					decodeInstr[sBit], rzNibble, decodeInstr[rnHi:rnLo],
					8'b0000_0000, decodeInstr[rnHi:rnLo]};
				ctrl = '{instrMux: 1'b1, doNotUpdateFlag: 1'b0, keepV: 1'b1,
					prevRsr: 1'b1, rzSel: 4'b0001};
				uOpStall = 1'b0;
				nextState = ready;
			end
			default: begin
				uopInstr = decodeInstr;
				ctrl = '0;
				uOpStall = 1'b0;
				nextState = ready;
			end
		endcase
	end

	// a bubble in decode must never stall fetch
	noStallOnBubble: assert property (
		@(posedge clk) disable iff (reset)
		(state == ready && !decodeValid) |-> !uOpStall
	) else $error("uop stall raised without a valid word");

	// every sequence state lasts one cycle unless ex holds it
	noRepeatState: assert property (
		@(posedge clk) disable iff (reset)
		(state != ready && !exStall) |=> (state != $past(state))
	) else $error("sequencer stuck in %s", state.name());

endmodule

/* rtl/regFileRz.sv */
// Register file with scratch register
module regFileRz (
	input logic clk,
	input logic reset,
	input decodePkg::regAddrT ra1,
	input decodePkg::regAddrT ra2,
	input decodePkg::writebackT wb,           // write port from writeback
	output logic [31:0] rd1,
	output logic [31:0] rd2
);

	import decodePkg::*;

	logic [31:0] regs [16];                   // architectural r0..r15
	logic [31:0] rz;                          // scratch for micro-ops

	// one read port, bypassed from writeback
	function automatic logic [31:0] readPort(regAddrT addr);
		if (addr[4] && (addr != rzAddr)) begin
			return '0;                          // undefined extended reg
		end
		if (wb.en && (wb.addr == addr)) begin
			return wb.data;                     // same-cycle write wins
		end
		if (addr[4]) begin
			return rz;
		end
		return regs[addr[3:0]];
	endfunction

	always_comb begin
		rd1 = readPort(ra1);
		rd2 = readPort(ra2);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
			rz <= '0;
		end else if (wb.en) begin
			if (!wb.addr[4]) begin
				regs[wb.addr[3:0]] <= wb.data;
			end else if (wb.addr == rzAddr) begin
				rz <= wb.data;
			end
		end
	end

	// writeback may only reach the extended bank through rz
	wbTargetDefined: assert property (
		@(posedge clk) disable iff (reset)
		(wb.en && wb.addr[4]) |-> (wb.addr == rzAddr)
	) else $error("write to undefined extended register %0d", wb.addr);

endmodule

/* rtl/decodeStage.sv */
// Decode stage front end
module decodeStage (
	input logic clk,
	input logic reset,
	input decodePkg::instrT fetchInstr,
	input logic fetchValid,
	input logic exStall,                      // downstream stall
	input decodePkg::writebackT wb,
	output logic fetchStall,                  // fetch holds its word
	output decodePkg::decodeOutT decodeOut
);

	import decodePkg::*;

	instrT decodeInstr;
	logic decodeValid;
	instrT uopInstr;
	uopCtrlT ctrl;
	logic uOpStall;
	regAddrT ra1;
	regAddrT ra2;
	logic [31:0] rd1;
	logic [31:0] rd2;

	assign fetchStall = uOpStall | exStall;   // also freezes the f/d register

	fetchDecodeReg fetchDecodeReg_i (
		.clk,
		.reset,
		.fetchInstr,
		.fetchValid,
		.hold(fetchStall),
		.decodeInstr,
		.decodeValid
	);

	microOpSequencer microOpSequencer_i (
		.clk,
		.reset,
		.decodeInstr,
		.decodeValid,
		.exStall,
		.uopInstr,
		.ctrl,
		.uOpStall
	);

	// Rn and Rm fields widened by the extended bank bits
	assign ra1 = ctrl.rzSel[3] ? rzAddr : {ctrl.rzSel[0], uopInstr[rnHi:rnLo]};
	assign ra2 = {ctrl.rzSel[1], uopInstr[rmHi:rmLo]};

	regFileRz regFileRz_i (
		.clk,
		.reset,
		.ra1,
		.ra2,
		.wb,
		.rd1,
		.rd2
	);

	assign decodeOut.valid = decodeValid;
	assign decodeOut.uopInstr = uopInstr;
	assign decodeOut.ctrl = ctrl;             // rzSel[2] goes on for the write address
	assign decodeOut.rd1 = rd1;
	assign decodeOut.rd2 = rd2;

endmodule

/* testbench/decodeChecker.sv */
// Decode output checker
module decodeChecker (
	input logic clk,
	input logic reset,
	input logic checkEn,                      // a stim row is being applied
	input logic [127:0] testName,
	input logic lastOfTest,                   // this row closes its test
	input logic [5:0] careMask,               // {rd2, rd1, ctrl, uop, valid, stall}
	input logic expFetchStall,
	input decodePkg::decodeOutT expOut,
	input logic allDone,
	input logic fetchStall,
	input decodePkg::decodeOutT decodeOut,
	output int errorCount
);

	timeunit 1ns;
	timeprecision 1ps;

	int testErrors = 0;                       // mismatches in the running test
	int testsPassed = 0;
	int testsFailed = 0;
	int resetEdges = 0;
	bit resetReported = 1'b0;
	bit summaryDone = 1'b0;

	initial begin
		errorCount = 0;
	end

	task automatic checkField(input bit care, input string field, input logic [31:0] expV,
		input logic [31:0] actV);
		if (care && (actV !== expV)) begin
			$display("Fail %s %s: expected %h, actual %h", string'(testName), field, expV, actV);
			testErrors++;
			errorCount++;
		end
	endtask

	task automatic reportTest(input string name);
		if (testErrors == 0) begin
			$display("test %s: pass", name);
			testsPassed++;
		end else begin
			$display("test %s: %0d mismatches", name, testErrors);
			testsFailed++;
		end
		testErrors = 0;                         // next test starts clean
	endtask

	// outputs settle half a cycle after the falling-edge drive
	always @(posedge clk) begin
		if (reset) begin
			if (resetEdges > 0) begin             // registers are known after the first edge
				checkField(1'b1, "fetchStall", 32'd0, {31'b0, fetchStall});
				checkField(1'b1, "valid", 32'd0, {31'b0, decodeOut.valid});
				checkField(1'b1, "ctrl", 32'd0, {24'b0, decodeOut.ctrl});
			end
			resetEdges++;
		end else begin
			if (!resetReported) begin
				reportTest("reset");
				resetReported = 1'b1;
			end
			if (checkEn) begin
				checkField(careMask[0], "fetchStall", {31'b0, expFetchStall}, {31'b0, fetchStall});
				checkField(careMask[1], "valid", {31'b0, expOut.valid}, {31'b0, decodeOut.valid});
				checkField(careMask[2], "uopInstr", expOut.uopInstr, decodeOut.uopInstr);
				checkField(careMask[3], "ctrl", {24'b0, expOut.ctrl}, {24'b0, decodeOut.ctrl});
				checkField(careMask[4], "rd1", expOut.rd1, decodeOut.rd1);
				checkField(careMask[5], "rd2", expOut.rd2, decodeOut.rd2);
				if (lastOfTest) begin
					reportTest(string'(testName));
				end
			end
			if (allDone && !summaryDone) begin
				$display("%0d tests: %0d passed, %0d failed, %0d mismatches",
					testsPassed + testsFailed, testsPassed, testsFailed, errorCount);
				summaryDone = 1'b1;
			end
		end
	end

endmodule

/* testbench/decodeStageTb.sv */
// Decode stage testbench
module decodeStageTb;

	timeunit 1ns;
	timeprecision 1ps;

	import decodePkg::*;

	localparam int maxRows = 64;
	localparam string stimPath = "testbench/decodeStim.txt";

	// one stim line with inputs and expected outputs
	typedef struct packed {
		logic [127:0] name;
		instrT fetchInstr;
		logic fetchValid;
		logic exStall;
		writebackT wb;
		logic expFetchStall;
		decodeOutT expOut;
		logic [5:0] careMask;
	} stimRowT;

	logic clk = 1'b0;
	logic reset;
	instrT fetchInstr;
	logic fetchValid;
	logic exStall;
	writebackT wb;
	logic fetchStall;
	decodeOutT decodeOut;

	logic checkEn;                            // expected record for the checker
	logic [127:0] testName;
	logic lastOfTest;
	logic [5:0] careMask;
	logic expFetchStall;
	decodeOutT expOut;
	logic allDone;
	int errorCount;

	stimRowT rows [maxRows];
	int rowCount = 0;
	int cycleCount = 0;
	int cycleLimit = 50;

	decodeStage dut_i (
		.clk,
		.reset,
		.fetchInstr,
		.fetchValid,
		.exStall,
		.wb,
		.fetchStall,
		.decodeOut
	);

	decodeChecker checker_i (
		.clk,
		.reset,
		.checkEn,
		.testName,
		.lastOfTest,
		.careMask,
		.expFetchStall,
		.expOut,
		.allDone,
		.fetchStall,
		.decodeOut,
		.errorCount
	);

	initial begin
		forever begin
			#2 clk = ~clk;                        // 4 ns period
		end
	end

	task automatic finishRun(input bit failed);
		if (failed) begin
			$display("Simulation finished: FAIL");
		end else begin
			$display("Simulation finished: PASS");
		end
		$finish;
	endtask

	task automatic loadStim();
		int fd;
		int n;
		string line;
		logic [127:0] name;
		logic [31:0] instr, fv, ex, wen, waddr, wdata;
		logic [31:0] estall, evalid, euop, ectrl, erd1, erd2, care;
		fd = $fopen(stimPath, "r");
		if (fd == 0) begin
			$display("could not open the stimulus file %s", stimPath);
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 0 && line[0] != "#") begin   // skip the column notes
				n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h", name, instr, fv,
					ex, wen, waddr, wdata, estall, evalid, euop, ectrl, erd1, erd2, care);
				if (n == 14 && rowCount < maxRows) begin
					rows[rowCount] = '{name: name, fetchInstr: instr, fetchValid: fv[0],
						exStall: ex[0], wb: '{en: wen[0], addr: waddr[4:0], data: wdata},
						expFetchStall: estall[0],
						expOut: '{valid: evalid[0], uopInstr: euop, ctrl: ectrl[7:0],
						rd1: erd1, rd2: erd2}, careMask: care[5:0]};
					rowCount++;
				end
			end
		end
		$fclose(fd);
	endtask

	// a test ends where the next row carries another name
	function automatic logic closesTest(int i);
		if (i == rowCount - 1) begin
			return 1'b1;
		end
		return rows[i + 1].name != rows[i].name;
	endfunction

	task automatic applyRow(int i);
		fetchInstr = rows[i].fetchInstr;
		fetchValid = rows[i].fetchValid;
		exStall = rows[i].exStall;
		wb = rows[i].wb;
		testName = rows[i].name;
		lastOfTest = closesTest(i);
		careMask = rows[i].careMask;
		expFetchStall = rows[i].expFetchStall;
		expOut = rows[i].expOut;
		checkEn = 1'b1;
	endtask

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= cycleLimit) begin
			$display("timeout: run did not finish within %0d cycles", cycleLimit);
			finishRun(1'b1);
		end
	end

	initial begin
		reset = 1'b1;
		fetchInstr = '0;
		fetchValid = 1'b0;
		exStall = 1'b0;
		wb = '0;
		checkEn = 1'b0;
		testName = 128'("reset");
		lastOfTest = 1'b0;
		careMask = '0;
		expFetchStall = 1'b0;
		expOut = '0;
		allDone = 1'b0;
		loadStim();
		cycleLimit = 2 * rowCount + 50;         // each row is one cycle
		if (rowCount == 0) begin
			$display("no stimulus rows were read from %s", stimPath);
			finishRun(1'b1);
		end else begin
			repeat (8) @(negedge clk);
			reset = 1'b0;
			for (int i = 0; i < rowCount; i++) begin
				applyRow(i);
				@(negedge clk);
			end
			checkEn = 1'b0;
			allDone = 1'b1;                       // checker prints its counts at the next edge
			@(negedge clk);
			finishRun(errorCount != 0);
		end
	end

endmodule

/* testbench/decodeStim.txt */
# name fetchInstr fetchValid exStall wbEn wbAddr wbData | fetchStall valid uopInstr ctrl rd1 rd2
# last column is the care mask {rd2 rd1 ctrl uop valid stall}, all hex, one row per cycle
idle     00000000 0 0 0 00 00000000 0 0 00000000 00 00000000 00000000 0b
passThru 00000000 0 0 1 01 11111111 0 0 00000000 00 00000000 00000000 0b
passThru e0813002 1 0 1 02 22222222 0 0 00000000 00 00000000 00000000 0b
passThru 00000000 0 0 1 02 33333333 0 1 e0813002 00 11111111 33333333 3f
rsr      e0814312 1 0 0 00 00000000 0 0 00000000 00 00000000 00000000 0b
rsr      00000000 0 0 1 1f cafe0001 1 1 e1a0f312 cc cafe0001 33333333 3f
rsr      00000000 0 0 0 00 00000000 0 1 e081400f 92 11111111 cafe0001 3f
mla      e0354392 1 0 1 04 44444444 0 0 00000000 00 00000000 00000000 0b
mla      00000000 0 0 1 1f 00000006 1 1 e00f0392 a4 00000000 33333333 3f
mla      00000000 0 0 0 00 00000000 0 1 e09f5004 b1 00000006 44444444 3f
longAcc  e0a76392 1 0 1 06 66666666 0 0 00000000 00 00000000 00000000 0b
longAcc  00000000 0 0 1 1f 0000aaaa 1 1 e08ff392 a4 00000000 33333333 3f
longAcc  00000000 0 0 1 1f 0000bbbb 1 1 e09f6006 e1 0000bbbb 66666666 3f
longAcc  00000000 0 0 0 00 00000000 0 1 e0af7007 b1 0000bbbb 00000000 3f
longAcc  00000000 0 0 0 00 00000000 0 0 00000000 00 00000000 00000000 0b
exStall  e0814312 1 0 0 00 00000000 0 0 00000000 00 00000000 00000000 0b
exStall  00000000 0 1 0 00 00000000 1 1 e1a0f312 cc 0000bbbb 33333333 3f
exStall  00000000 0 1 0 00 00000000 1 1 e1a0f312 cc 0000bbbb 33333333 3f
exStall  00000000 0 0 0 00 00000000 1 1 e1a0f312 cc 0000bbbb 33333333 3f
exStall  00000000 0 0 0 00 00000000 0 1 e081400f 92 11111111 0000bbbb 3f
exStall  00000000 0 0 0 00 00000000 0 0 00000000 00 00000000 00000000 0b

/* files.f */
+incdir+include
rtl/decodePkg.sv
rtl/fetchDecodeReg.sv
rtl/microOpSequencer.sv
rtl/regFileRz.sv
rtl/decodeStage.sv
testbench/decodeChecker.sv
testbench/decodeStageTb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	-f files.f --top-module decodeStageTb -o decodeStageSim

./obj_dir/decodeStageSim | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
	exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
	echo "no verdict found in sim.log"
	exit 1
fi
